// File: hw/commit_unit.sv
/* Registers the commit record for the checker, gates retirement, detects
   the halt instruction and keeps the cycle and instruction counters. */
module commit_unit #(
  parameter int CNT_W = 64
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_cmt_valid,
  input  rv_pkg::xlen_t    i_pc,
  input  rv_pkg::inst_t    i_inst,
  input  rv_pkg::reg_idx_t i_rd,
  input  logic             i_rd_wen,
  input  rv_pkg::xlen_t    i_rd_wdata,
  input  logic             i_skip,
  input  logic [31:0]      i_intr_no,
  input  rv_pkg::xlen_t    i_a0,
  output logic             o_retire_en,
  output logic             o_cmt_valid,
  output rv_pkg::xlen_t    o_cmt_pc,
  output rv_pkg::inst_t    o_cmt_inst,
  output logic             o_cmt_wen,
  output logic [7:0]       o_cmt_wdest,
  output rv_pkg::xlen_t    o_cmt_wdata,
  output logic             o_cmt_skip,
  output logic             o_halt,
  output logic [rv_pkg::HALT_CODE_W-1:0] o_halt_code,
  output logic [CNT_W-1:0] o_cycle_cnt,
  output logic [CNT_W-1:0] o_instr_cnt
);

  logic is_halt;
  logic halted;
  logic [rv_pkg::HALT_CODE_W-1:0] halt_code;
  logic [CNT_W-1:0] cycle_cnt;
  logic [CNT_W-1:0] instr_cnt;

  assign is_halt = i_cmt_valid && (i_inst[6:0] == rv_pkg::HALT_OPCODE);

  // halting instruction itself updates no state either
  assign o_retire_en = i_cmt_valid && !halted && !is_halt;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_cmt_valid <= 1'b0;
      o_cmt_pc    <= '0;
      o_cmt_inst  <= '0;
      o_cmt_wen   <= 1'b0;
      o_cmt_wdest <= '0;
      o_cmt_wdata <= '0;
      o_cmt_skip  <= 1'b0;
      halted      <= 1'b0;
      halt_code   <= '0;
      cycle_cnt   <= '0;
      instr_cnt   <= '0;
    end else if (!halted) begin
      o_cmt_valid <= i_cmt_valid && (i_intr_no == 32'd0);  // intr is not a commit
      o_cmt_pc    <= i_pc;
      o_cmt_inst  <= i_inst;
      o_cmt_wen   <= i_rd_wen;
      o_cmt_wdest <= {3'd0, i_rd};
      o_cmt_wdata <= i_rd_wdata;
      o_cmt_skip  <= i_skip;
      cycle_cnt   <= cycle_cnt + 1'b1;
      instr_cnt   <= instr_cnt + CNT_W'(i_cmt_valid);
      if (is_halt) begin
        halted    <= 1'b1;
        halt_code <= i_a0[rv_pkg::HALT_CODE_W-1:0];
      end
    end
  end

  assign o_halt      = halted;
  assign o_halt_code = halt_code;
  assign o_cycle_cnt = cycle_cnt;
  assign o_instr_cnt = instr_cnt;

  // halt is sticky until the next reset
  a_halt_sticky : assert property (
    @(posedge clk) disable iff (rst)
    o_halt |=> o_halt
  ) else $error("halt dropped without reset");

  a_wdest_range : assert property (
    @(posedge clk) disable iff (rst)
    o_cmt_wdest < 8'd32
  ) else $error("commit wdest out of range");

endmodule

// File: hw/csr_file.sv
/* Machine-mode CSRs updated at retire: csrrw/csrrs/csrrc, interrupt entry
   and mret. Writes land one cycle after the enabling retire. */
module csr_file (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_en,
  input  rv_pkg::csr_op_e   i_op,
  input  rv_pkg::csr_addr_t i_addr,
  input  rv_pkg::xlen_t     i_wdata,
  input  logic [31:0]       i_intr_no,
  input  rv_pkg::xlen_t     i_pc,
  output rv_pkg::xlen_t     o_mstatus,
  output rv_pkg::xlen_t     o_sstatus,
  output rv_pkg::xlen_t     o_mie,
  output rv_pkg::xlen_t     o_mtvec,
  output rv_pkg::xlen_t     o_mscratch,
  output rv_pkg::xlen_t     o_mepc,
  output rv_pkg::xlen_t     o_mcause
);

  rv_pkg::xlen_t mstatus;
  rv_pkg::xlen_t mie;
  rv_pkg::xlen_t mtvec;
  rv_pkg::xlen_t mscratch;
  rv_pkg::xlen_t mepc;
  rv_pkg::xlen_t mcause;
  rv_pkg::xlen_t csr_old;
  rv_pkg::xlen_t csr_new;
  logic          intr;
  logic          csr_wr;

  assign intr   = (i_intr_no != 32'd0);
  assign csr_wr = (i_op == rv_pkg::CSR_RW) || (i_op == rv_pkg::CSR_RS) ||
                  (i_op == rv_pkg::CSR_RC);

  // current value of the addressed csr
  always_comb begin
    case (i_addr)
      rv_pkg::CSR_MSTATUS:  csr_old = mstatus;
      rv_pkg::CSR_MIE:      csr_old = mie;
      rv_pkg::CSR_MTVEC:    csr_old = mtvec;
      rv_pkg::CSR_MSCRATCH: csr_old = mscratch;
      rv_pkg::CSR_MEPC:     csr_old = mepc;
      rv_pkg::CSR_MCAUSE:   csr_old = mcause;
      default:              csr_old = '0;  // unknown csr
    endcase
  end

  always_comb begin
    case (i_op)
      rv_pkg::CSR_RW: csr_new = i_wdata;
      rv_pkg::CSR_RS: csr_new = csr_old | i_wdata;
      rv_pkg::CSR_RC: csr_new = csr_old & ~i_wdata;
      default:        csr_new = csr_old;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus  <= '0;
      mie      <= '0;
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
    end else if (i_en) begin
      if (intr) begin  // interrupt entry wins over the csr op
        mepc                         <= i_pc;
        mcause                       <= rv_pkg::MCAUSE_INTR | {32'd0, i_intr_no};
        mstatus[rv_pkg::MSTATUS_MPIE] <= mstatus[rv_pkg::MSTATUS_MIE];
        mstatus[rv_pkg::MSTATUS_MIE]  <= 1'b0;
      end else if (i_op == rv_pkg::CSR_MRET) begin
        mstatus[rv_pkg::MSTATUS_MIE]  <= mstatus[rv_pkg::MSTATUS_MPIE];
        mstatus[rv_pkg::MSTATUS_MPIE] <= 1'b1;
      end else if (csr_wr) begin
        case (i_addr)
          rv_pkg::CSR_MSTATUS:  mstatus  <= csr_new;
          rv_pkg::CSR_MIE:      mie      <= csr_new;
          rv_pkg::CSR_MTVEC:    mtvec    <= csr_new;
          rv_pkg::CSR_MSCRATCH: mscratch <= csr_new;
          rv_pkg::CSR_MEPC:     mepc     <= csr_new;
          rv_pkg::CSR_MCAUSE:   mcause   <= csr_new;
          default: ;  // ignored
        endcase
      end
    end
  end

  assign o_mstatus  = mstatus;
  assign o_sstatus  = mstatus & rv_pkg::SSTATUS_MASK;
  assign o_mie      = mie;
  assign o_mtvec    = mtvec;
  assign o_mscratch = mscratch;
  assign o_mepc     = mepc;
  assign o_mcause   = mcause;

  // execute stage never pairs an mret with an interrupt
  a_no_mret_intr : assert property (
    @(posedge clk) disable iff (rst)
    (i_en && intr) |-> (i_op != rv_pkg::CSR_MRET)
  ) else $error("mret retired together with an interrupt");

endmodule

// File: hw/gpr_file.sv
/* Architectural integer register file, 32 x 64 with x0 tied to zero.
   Written at retire, one read port plus a fixed a0 tap for the halt code. */
module gpr_file (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_we,
  input  rv_pkg::reg_idx_t i_waddr,
  input  rv_pkg::xlen_t    i_wdata,
  input  rv_pkg::reg_idx_t i_raddr,
  output rv_pkg::xlen_t    o_rdata,
  output rv_pkg::xlen_t    o_a0
);

  rv_pkg::xlen_t regs [0:31];
  logic          wr_ok;

  assign wr_ok = i_we && (i_waddr != 5'd0);  // x0 writes dropped

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // registered write so a same-cycle read sees the old value
  assign o_rdata = regs[i_raddr];

  assign o_a0 = regs[rv_pkg::A0_IDX];  // halt code source

  // x0 reads zero as long as its storage is never written
  a_x0_read : assert property (
    @(posedge clk) disable iff (rst)
    (i_raddr == 5'd0) |-> (o_rdata == '0)
  ) else $error("x0 read nonzero");

endmodule

// File: hw/retire_top.sv
/* Retirement subsystem top: register file, machine CSRs and commit unit.
   Retire stream in, commit record, counters and CSR state out. */
module retire_top #(
  parameter int CNT_W = 64
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_cmt_valid,
  input  rv_pkg::xlen_t     i_pc,
  input  rv_pkg::inst_t     i_inst,
  input  rv_pkg::reg_idx_t  i_rd,
  input  logic              i_rd_wen,
  input  rv_pkg::xlen_t     i_rd_wdata,
  input  logic              i_skip,
  input  logic [31:0]       i_intr_no,
  input  rv_pkg::csr_op_e   i_csr_op,
  input  rv_pkg::csr_addr_t i_csr_addr,
  input  rv_pkg::xlen_t     i_csr_wdata,
  input  rv_pkg::reg_idx_t  i_gpr_raddr,
  output rv_pkg::xlen_t     o_gpr_rdata,
  output logic              o_cmt_valid,
  output rv_pkg::xlen_t     o_cmt_pc,
  output rv_pkg::inst_t     o_cmt_inst,
  output logic              o_cmt_wen,
  output logic [7:0]        o_cmt_wdest,
  output rv_pkg::xlen_t     o_cmt_wdata,
  output logic              o_cmt_skip,
  output logic              o_halt,
  output logic [rv_pkg::HALT_CODE_W-1:0] o_halt_code,
  output logic [CNT_W-1:0]  o_cycle_cnt,
  output logic [CNT_W-1:0]  o_instr_cnt,
  output rv_pkg::xlen_t     o_mstatus,
  output rv_pkg::xlen_t     o_sstatus,
  output rv_pkg::xlen_t     o_mie,
  output rv_pkg::xlen_t     o_mtvec,
  output rv_pkg::xlen_t     o_mscratch,
  output rv_pkg::xlen_t     o_mepc,
  output rv_pkg::xlen_t     o_mcause
);

  logic          retire_en;
  logic          gpr_we;
  rv_pkg::xlen_t a0;

  assign gpr_we = retire_en & i_rd_wen;

  gpr_file u_gpr (
    .clk     (clk),
    .rst     (rst),
    .i_we    (gpr_we),
    .i_waddr (i_rd),
    .i_wdata (i_rd_wdata),
    .i_raddr (i_gpr_raddr),
    .o_rdata (o_gpr_rdata),
    .o_a0    (a0)
  );

  csr_file u_csr (
    .clk        (clk),
    .rst        (rst),
    .i_en       (retire_en),
    .i_op       (i_csr_op),
    .i_addr     (i_csr_addr),
    .i_wdata    (i_csr_wdata),
    .i_intr_no  (i_intr_no),
    .i_pc       (i_pc),
    .o_mstatus  (o_mstatus),
    .o_sstatus  (o_sstatus),
    .o_mie      (o_mie),
    .o_mtvec    (o_mtvec),
    .o_mscratch (o_mscratch),
    .o_mepc     (o_mepc),
    .o_mcause   (o_mcause)
  );

  commit_unit #(
    .CNT_W (CNT_W)
  ) u_cmt (
    .clk         (clk),
    .rst         (rst),
    .i_cmt_valid (i_cmt_valid),
    .i_pc        (i_pc),
    .i_inst      (i_inst),
    .i_rd        (i_rd),
    .i_rd_wen    (i_rd_wen),
    .i_rd_wdata  (i_rd_wdata),
    .i_skip      (i_skip),
    .i_intr_no   (i_intr_no),
    .i_a0        (a0),
    .o_retire_en (retire_en),
    .o_cmt_valid (o_cmt_valid),
    .o_cmt_pc    (o_cmt_pc),
    .o_cmt_inst  (o_cmt_inst),
    .o_cmt_wen   (o_cmt_wen),
    .o_cmt_wdest (o_cmt_wdest),
    .o_cmt_wdata (o_cmt_wdata),
    .o_cmt_skip  (o_cmt_skip),
    .o_halt      (o_halt),
    .o_halt_code (o_halt_code),
    .o_cycle_cnt (o_cycle_cnt),
    .o_instr_cnt (o_instr_cnt)
  );

endmodule

// File: hw/rv_pkg.sv
/* Shared types and constants for the retirement subsystem.
   Referenced by scoped name from every RTL block. */
package rv_pkg;

  localparam int XLEN = 64;
  localparam int ILEN = 32;

  typedef logic [XLEN-1:0] xlen_t;     // regs, csrs, pc
  typedef logic [ILEN-1:0] inst_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [11:0]     csr_addr_t;

  // csr operation carried with each retire
  typedef enum logic [2:0] {
    CSR_NONE = 3'd0,
    CSR_RW   = 3'd1,
    CSR_RS   = 3'd2,
    CSR_RC   = 3'd3,
    CSR_MRET = 3'd4
  } csr_op_e;

  // machine csr addresses
  localparam csr_addr_t CSR_MSTATUS  = 12'h300;
  localparam csr_addr_t CSR_MIE      = 12'h304;
  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;

  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;

  localparam xlen_t MCAUSE_INTR  = 64'h80000000_00000000;  // interrupt flag in mcause
  localparam xlen_t SSTATUS_MASK = 64'h80000003_000DE122;  // sstatus bits of mstatus

  // simulation halt opcode and the code taken from a0
  localparam logic [6:0] HALT_OPCODE = 7'h6b;
  localparam reg_idx_t   A0_IDX      = 5'd10;
  localparam int         HALT_CODE_W = 3;

endpackage

// File: retire.f
hw/rv_pkg.sv
hw/gpr_file.sv
hw/csr_file.sv
hw/commit_unit.sv
hw/retire_top.sv
tb/retire_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the retire testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module retire_tb \
  -f retire.f -o retire_sim

out=$(./obj_dir/retire_sim || true)
echo "$out"

if echo "$out" | grep -qx "RESULT: PASS"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

// File: tb/retire_tb.sv
/* Testbench for retire_top. Drives retire streams on the falling edge and
   checks the commit record, registers, CSRs, counters and halt against a model. */
module retire_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CNT_W     = 64;
  localparam int RESET_CYC = 8;
  localparam int RAND_CYC  = 120;
  localparam int CSR_CYC   = 21;  // 7 addresses x 3 ops
  localparam int INTR_CYC  = 6;
  localparam int CNT_CYC   = 12;
  localparam int HALT_CYC  = 24;
  localparam int LIMIT_CYC = RESET_CYC + RAND_CYC + CSR_CYC + INTR_CYC + CNT_CYC +
                             HALT_CYC + 50;

  localparam rv_pkg::csr_addr_t CSR_LIST [0:6] = '{rv_pkg::CSR_MSTATUS, rv_pkg::CSR_MIE,
    rv_pkg::CSR_MTVEC, rv_pkg::CSR_MSCRATCH, rv_pkg::CSR_MEPC, rv_pkg::CSR_MCAUSE, 12'h7c0};
  localparam rv_pkg::csr_op_e OPS [0:2] = '{rv_pkg::CSR_RW, rv_pkg::CSR_RS, rv_pkg::CSR_RC};

  logic              clk;
  logic              rst;
  logic              i_cmt_valid;
  rv_pkg::xlen_t     i_pc;
  rv_pkg::inst_t     i_inst;
  rv_pkg::reg_idx_t  i_rd;
  logic              i_rd_wen;
  rv_pkg::xlen_t     i_rd_wdata;
  logic              i_skip;
  logic [31:0]       i_intr_no;
  rv_pkg::csr_op_e   i_csr_op;
  rv_pkg::csr_addr_t i_csr_addr;
  rv_pkg::xlen_t     i_csr_wdata;
  rv_pkg::reg_idx_t  i_gpr_raddr;
  rv_pkg::xlen_t     o_gpr_rdata;
  logic              o_cmt_valid;
  rv_pkg::xlen_t     o_cmt_pc;
  rv_pkg::inst_t     o_cmt_inst;
  logic              o_cmt_wen;
  logic [7:0]        o_cmt_wdest;
  rv_pkg::xlen_t     o_cmt_wdata;
  logic              o_cmt_skip;
  logic              o_halt;
  logic [rv_pkg::HALT_CODE_W-1:0] o_halt_code;
  logic [CNT_W-1:0]  o_cycle_cnt;
  logic [CNT_W-1:0]  o_instr_cnt;
  rv_pkg::xlen_t     o_mstatus;
  rv_pkg::xlen_t     o_sstatus;
  rv_pkg::xlen_t     o_mie;
  rv_pkg::xlen_t     o_mtvec;
  rv_pkg::xlen_t     o_mscratch;
  rv_pkg::xlen_t     o_mepc;
  rv_pkg::xlen_t     o_mcause;

  // reference model state expected after the next rising edge
  rv_pkg::xlen_t    m_gpr [0:31];
  rv_pkg::xlen_t    m_csr [0:5];  // mstatus mie mtvec mscratch mepc mcause
  logic             m_halted;
  logic [2:0]       m_code;
  logic             e_valid;
  rv_pkg::xlen_t    e_pc;
  rv_pkg::inst_t    e_inst;
  logic             e_wen;
  rv_pkg::reg_idx_t e_wdest;
  rv_pkg::xlen_t    e_wdata;
  logic             e_skip;
  rv_pkg::xlen_t    e_cycle;
  rv_pkg::xlen_t    e_instr;
  int               seed;
  int               errors;
  int               checks;
  int               err0;
  int unsigned      tb_cyc;

  retire_top #(.CNT_W(CNT_W)) i_dut (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  function automatic int csr_slot(input rv_pkg::csr_addr_t addr);
    case (addr)
      rv_pkg::CSR_MSTATUS:  return 0;
      rv_pkg::CSR_MIE:      return 1;
      rv_pkg::CSR_MTVEC:    return 2;
      rv_pkg::CSR_MSCRATCH: return 3;
      rv_pkg::CSR_MEPC:     return 4;
      rv_pkg::CSR_MCAUSE:   return 5;
      default:              return -1;
    endcase
  endfunction

  function automatic void clear_model();
    for (int i = 0; i < 32; i++) begin
      m_gpr[i] = '0;
    end
    for (int i = 0; i < 6; i++) begin
      m_csr[i] = '0;
    end
    {m_halted, m_code, e_valid, e_wen, e_skip} = '0;
    {e_pc, e_inst, e_wdest, e_wdata, e_cycle, e_instr} = '0;
  endfunction

  // one clock of retirement in the reference model
  function automatic void predict_retire(input logic valid, input rv_pkg::xlen_t pc,
      input rv_pkg::inst_t inst, input rv_pkg::reg_idx_t rd, input logic wen,
      input rv_pkg::xlen_t wdata, input logic skip, input logic [31:0] intr,
      input rv_pkg::csr_op_e op, input rv_pkg::csr_addr_t addr, input rv_pkg::xlen_t cdata);
    int slot;
    slot = csr_slot(addr);
    if (m_halted) begin
      return;  // frozen
    end
    e_valid = valid && (intr == 32'd0);
    e_pc    = pc;
    e_inst  = inst;
    e_wen   = wen;
    e_wdest = rd;
    e_wdata = wdata;
    e_skip  = skip;
    e_cycle = e_cycle + 64'd1;
    if (valid) begin
      e_instr = e_instr + 64'd1;
    end
    if (valid && inst[6:0] == 7'h6b) begin
      m_halted = 1'b1;
      m_code   = m_gpr[10][2:0];  // a0
    end else if (valid) begin
      if (wen && rd != 5'd0) begin
        m_gpr[rd] = wdata;
      end
      if (intr != 32'd0) begin
        m_csr[4]    = pc;
        m_csr[5]    = {32'h8000_0000, intr};
        m_csr[0][7] = m_csr[0][3];
        m_csr[0][3] = 1'b0;
      end else if (op == rv_pkg::CSR_MRET) begin
        m_csr[0][3] = m_csr[0][7];
        m_csr[0][7] = 1'b1;
      end else if (op != rv_pkg::CSR_NONE && slot >= 0) begin
        case (op)
          rv_pkg::CSR_RW: m_csr[slot] = cdata;
          rv_pkg::CSR_RS: m_csr[slot] = m_csr[slot] | cdata;
          default:        m_csr[slot] = m_csr[slot] & ~cdata;
        endcase
      end
    end
  endfunction

  function automatic rv_pkg::xlen_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic rv_pkg::inst_t rand_inst();
    rv_pkg::inst_t inst;
    inst      = $random(seed);
    inst[6:0] = 7'h33;  // plain op that never halts
    return inst;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("** Error @%0t: %s", $time, msg);
  endtask

  task automatic check_word(input string name, input rv_pkg::xlen_t act,
      input rv_pkg::xlen_t exp);
    checks++;
    if (act !== exp) begin
      report_error($sformatf("%s is %h, expected %h", name, act, exp));
    end
  endtask

  task automatic check_commit(input logic valid, input rv_pkg::xlen_t pc,
      input rv_pkg::inst_t inst, input logic wen, input rv_pkg::reg_idx_t dest,
      input rv_pkg::xlen_t data, input logic skip);
    string got;
    string want;
    checks++;
    if (o_cmt_valid !== valid || o_cmt_pc !== pc || o_cmt_inst !== inst ||
        o_cmt_wen !== wen || o_cmt_wdest !== {3'd0, dest} || o_cmt_wdata !== data ||
        o_cmt_skip !== skip) begin
      got  = $sformatf("v%b pc %h inst %h wen %b rd %0d data %h skip %b", o_cmt_valid,
                       o_cmt_pc, o_cmt_inst, o_cmt_wen, o_cmt_wdest, o_cmt_wdata, o_cmt_skip);
      want = $sformatf("v%b pc %h inst %h wen %b rd %0d data %h skip %b", valid, pc, inst,
                       wen, dest, data, skip);
      report_error({"commit record ", got, ", expected ", want});
    end
  endtask

  task automatic check_halt(input logic halt, input logic [2:0] code);
    checks++;
    if (o_halt !== halt || o_halt_code !== code) begin
      report_error($sformatf("halt %b code %0d, expected %b code %0d", o_halt, o_halt_code,
                             halt, code));
    end
  endtask

  task automatic set_inputs(input logic valid, input rv_pkg::xlen_t pc,
      input rv_pkg::inst_t inst, input rv_pkg::reg_idx_t rd, input logic wen,
      input rv_pkg::xlen_t wdata, input logic skip, input logic [31:0] intr,
      input rv_pkg::csr_op_e op, input rv_pkg::csr_addr_t addr, input rv_pkg::xlen_t cdata);
    i_cmt_valid = valid;
    i_pc        = pc;
    i_inst      = inst;
    i_rd        = rd;
    i_rd_wen    = wen;
    i_rd_wdata  = wdata;
    i_skip      = skip;
    i_intr_no   = intr;
    i_csr_op    = op;
    i_csr_addr  = addr;
    i_csr_wdata = cdata;
  endtask

  // called on a falling edge and returns on the next one
  task automatic drive(input logic valid, input rv_pkg::xlen_t pc, input rv_pkg::inst_t inst,
      input rv_pkg::reg_idx_t rd, input logic wen, input rv_pkg::xlen_t wdata,
      input logic skip, input logic [31:0] intr, input rv_pkg::csr_op_e op,
      input rv_pkg::csr_addr_t addr, input rv_pkg::xlen_t cdata);
    set_inputs(valid, pc, inst, rd, wen, wdata, skip, intr, op, addr, cdata);
    i_gpr_raddr = 5'($random(seed));  // x0 reads included
    predict_retire(valid, pc, inst, rd, wen, wdata, skip, intr, op, addr, cdata);
    @(negedge clk);
  endtask

  task automatic idle();
    drive(1'b0, '0, '0, '0, 1'b0, '0, 1'b0, 32'd0, rv_pkg::CSR_NONE, '0, '0);
  endtask

  task automatic report_test(input string name);
    if (errors == err0) begin
      $display("test %s: passed", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - err0);
    end
    err0 = errors;
  endtask

  // compare process samples 1 ns after the rising edge
  initial begin
    forever begin
      @(posedge clk);
      #1;
      check_commit(e_valid, e_pc, e_inst, e_wen, e_wdest, e_wdata, e_skip);
      check_word("gpr read", o_gpr_rdata, m_gpr[i_gpr_raddr]);
      check_word("mstatus", o_mstatus, m_csr[0]);
      check_word("sstatus", o_sstatus, m_csr[0] & rv_pkg::SSTATUS_MASK);
      check_word("mie", o_mie, m_csr[1]);
      check_word("mtvec", o_mtvec, m_csr[2]);
      check_word("mscratch", o_mscratch, m_csr[3]);
      check_word("mepc", o_mepc, m_csr[4]);
      check_word("mcause", o_mcause, m_csr[5]);
      check_word("cycle count", o_cycle_cnt, e_cycle);
      check_word("instr count", o_instr_cnt, e_instr);
      check_halt(m_halted, m_code);
    end
  end

  initial begin
    tb_cyc = 0;
    while (tb_cyc < LIMIT_CYC) begin
      @(posedge clk);
      tb_cyc++;
    end
    $display("timeout: the tests did not finish within %0d cycles", LIMIT_CYC);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    seed   = 32'h4a72;
    errors = 0;
    checks = 0;
    err0   = 0;
    clear_model();
    rst = 1'b1;
    set_inputs(1'b0, '0, '0, '0, 1'b0, '0, 1'b0, 32'd0, rv_pkg::CSR_NONE, '0, '0);
    i_gpr_raddr = '0;
    repeat (RESET_CYC) @(negedge clk);
    rst = 1'b0;
    report_test("after reset");

    for (int n = 0; n < RAND_CYC; n++) begin
      drive(($random(seed) & 7) != 0, rand_word(), rand_inst(), 5'($random(seed)),
            1'($random(seed)), rand_word(), 1'($random(seed)), 32'd0, rv_pkg::CSR_NONE,
            12'($random(seed)), rand_word());
    end
    report_test("random retires");

    for (int a = 0; a < 7; a++) begin
      for (int k = 0; k < 3; k++) begin
        drive(1'b1, rand_word(), rand_inst(), 5'd0, 1'b0, '0, 1'b0, 32'd0, OPS[k],
              CSR_LIST[a], rand_word());
      end
    end
    report_test("csr operations");

    drive(1'b1, rand_word(), rand_inst(), 5'd0, 1'b0, '0, 1'b0, 32'd0, rv_pkg::CSR_RS,
          rv_pkg::CSR_MSTATUS, 64'h8);  // mie on
    drive(1'b1, rand_word(), rand_inst(), 5'd0, 1'b0, '0, 1'b0, 32'd0, rv_pkg::CSR_RC,
          rv_pkg::CSR_MSTATUS, 64'h80);  // mpie off
    drive(1'b1, 64'h8000_1000, rand_inst(), 5'd0, 1'b0, '0, 1'b0, 32'd7, rv_pkg::CSR_RW,
          rv_pkg::CSR_MSCRATCH, rand_word());  // interrupt beats the csr write
    idle();
    drive(1'b1, 64'h8000_2000, rand_inst(), 5'd0, 1'b0, '0, 1'b0, 32'd0, rv_pkg::CSR_MRET,
          '0, '0);
    idle();
    report_test("interrupt and mret");

    for (int n = 0; n < CNT_CYC; n++) begin
      if (n % 3 == 0) begin
        idle();
      end else begin
        drive(1'b1, rand_word(), rand_inst(), 5'($random(seed)), 1'b1, rand_word(), 1'b0,
              32'd0, rv_pkg::CSR_NONE, '0, '0);
      end
    end
    check_word("cycles since reset", o_cycle_cnt, 64'(tb_cyc - RESET_CYC));
    report_test("counters");

    drive(1'b1, rand_word(), rand_inst(), 5'd10, 1'b1, 64'h1234_5675, 1'b0, 32'd0,
          rv_pkg::CSR_NONE, '0, '0);  // a0 gives code 5
    drive(1'b1, rand_word(), 32'h0000_006b, 5'd5, 1'b1, rand_word(), 1'b0, 32'd0,
          rv_pkg::CSR_RW, rv_pkg::CSR_MSCRATCH, rand_word());
    for (int n = 0; n < HALT_CYC - 2; n++) begin
      drive(1'b1, rand_word(), rand_inst(), 5'($random(seed)), 1'b1, rand_word(),
            1'($random(seed)), (n == 5) ? 32'd3 : 32'd0, OPS[n % 3], CSR_LIST[n % 7],
            rand_word());
    end
    check_halt(1'b1, 3'd5);
    report_test("halt");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
